//--- hw/geom_pkg.sv
`default_nettype none

package geom_pkg;

    typedef logic signed [11:0] coord_t;   // arena coords, centre 0, y up
    typedef logic [11:0]        pix_t;     // screen coords, origin top left
    typedef logic [5:0]         rgb_t;     // rr gg bb
    typedef logic [25:0]        dist_t;    // squared distance

    localparam int SCREEN_W = 800;
    localparam int SCREEN_H = 600;

    localparam int SEG_STEP  = 30;
    localparam int SEG_R     = 20;
    localparam int SEG_AREA  = 400;
    localparam int FOOD_AREA = 225;
    localparam int EAT_AREA  = 1225;

    // head dies on or past these
    localparam int WALL_X      = 375;
    localparam int WALL_Y_TOP  = 225;
    localparam int WALL_Y_BOT  = -275;
    localparam int FLOOR_Y_TOP = 220;  // floor drawn a bit below the top wall check

    localparam int FOOD_PARK = 1000;
    localparam int FOOD_GRID = 20;     // food placement grid
    localparam int FOOD_COLS = 16;
    localparam int FOOD_ROWS = 11;
    localparam int FOOD_X0   = 160;
    localparam int FOOD_Y0   = 100;

    localparam rgb_t COL_SNAKE = 6'b00_11_00;
    localparam rgb_t COL_FOOD  = 6'b11_00_00;
    localparam rgb_t COL_FLOOR = 6'b00_00_00;
    localparam rgb_t COL_WALL  = 6'b11_11_11;

    function automatic dist_t dist2(input coord_t ax, input coord_t ay,
                                    input coord_t bx, input coord_t by);
        logic signed [25:0] dx;
        logic signed [25:0] dy;
        dx = 26'(ax) - 26'(bx);
        dy = 26'(ay) - 26'(by);
        return dist_t'(dx * dx + dy * dy);
    endfunction

endpackage

`default_nettype wire

//--- hw/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef enum logic [1:0] {
        IDLE,
        PLAY,
        OVER
    } game_state_t;

    typedef enum logic [1:0] {
        RIGHT,
        LEFT,
        UP,
        DOWN
    } dir_t;

    typedef logic [3:0] len_t;

    localparam len_t LEN_INIT = 4'd5;   // segments at reset

    // random counter wraps after this value
    localparam int RND_TOP = 1000;

endpackage

`default_nettype wire

//--- hw/snake_if.sv
`timescale 1ns/100ps
`default_nettype none

interface snake_if
    import geom_pkg::*, game_pkg::*;
#(
    parameter int MAX_LEN = 10
) ();

    coord_t seg_x [MAX_LEN];   // index 0 is the head
    coord_t seg_y [MAX_LEN];
    len_t   length;

    modport body (
        output seg_x,
        output seg_y,
        output length
    );

    modport view (
        input seg_x,
        input seg_y,
        input length
    );

endinterface

`default_nettype wire

//--- hw/game_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module game_ctrl
    import geom_pkg::*, game_pkg::*;
#(
    parameter int STEP_CYCLES = 25000000
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        btn_left,
    input  logic        btn_right,
    input  logic        btn_up,
    input  logic        btn_down,
    snake_if.view       body,
    output game_state_t state,
    output dir_t        dir,
    output logic        step
);

    localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STEP_CYCLES - 1);

    logic [CNT_W-1:0] step_cnt;
    logic             any_btn;
    logic             wall_hit;
    dir_t             dir_next;

    assign any_btn = btn_left | btn_right | btn_up | btn_down;

    // registered head against the walls
    assign wall_hit = (body.seg_x[0] >= WALL_X) || (body.seg_x[0] <= -WALL_X) ||
                      (body.seg_y[0] >= WALL_Y_TOP) || (body.seg_y[0] <= WALL_Y_BOT);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= IDLE;
            step_cnt <= '0;
            step     <= 1'b0;
        end else begin
            step <= 1'b0;
            case (state)
                IDLE: begin
                    step_cnt <= '0;
                    if (any_btn)
                        state <= PLAY;
                end
                PLAY: begin
                    if (wall_hit) begin
                        state <= OVER;
                    end else if (step_cnt == CNT_LAST) begin
                        step_cnt <= '0;
                        step     <= 1'b1;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= OVER;   // dead until reset
                end
            endcase
        end
    end

    // only right-angle turns, reversals fall through
    always_comb begin
        dir_next = dir;
        if (dir == RIGHT || dir == LEFT) begin
            if (btn_up)
                dir_next = UP;
            else if (btn_down)
                dir_next = DOWN;
        end else begin
            if (btn_left)
                dir_next = LEFT;
            else if (btn_right)
                dir_next = RIGHT;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET)
            dir <= RIGHT;
        else if (state == PLAY)
            dir <= dir_next;  // sampled every cycle, not just on step
    end

endmodule

`default_nettype wire

//--- hw/snake_body.sv
`timescale 1ns/100ps
`default_nettype none

module snake_body
    import geom_pkg::*, game_pkg::*;
#(
    parameter int MAX_LEN = 10
) (
    input  logic    CLK,
    input  logic    RESET,
    input  logic    step,
    input  dir_t    dir,
    input  logic    eaten,
    snake_if.body   body
);

    coord_t head_x_next;
    coord_t head_y_next;
    coord_t tail_x;
    coord_t tail_y;

    always_comb begin
        head_x_next = body.seg_x[0];
        head_y_next = body.seg_y[0];
        case (dir)
            RIGHT: head_x_next = coord_t'(body.seg_x[0] + SEG_STEP);
            LEFT:  head_x_next = coord_t'(body.seg_x[0] - SEG_STEP);
            UP:    head_y_next = coord_t'(body.seg_y[0] + SEG_STEP);
            DOWN:  head_y_next = coord_t'(body.seg_y[0] - SEG_STEP);
            default: ;
        endcase
    end

    // last live segment, unused slots pile up on it
    assign tail_x = body.seg_x[body.length - 1'b1];
    assign tail_y = body.seg_y[body.length - 1'b1];

    always_ff @(posedge CLK) begin
        if (RESET) begin
            for (int i = 0; i < MAX_LEN; i++) begin
                if (i < int'(LEN_INIT))
                    body.seg_x[i] <= coord_t'((int'(LEN_INIT) - 1 - i) * SEG_R);
                else
                    body.seg_x[i] <= '0;
                body.seg_y[i] <= '0;
            end
        end else if (step) begin
            body.seg_x[0] <= head_x_next;
            body.seg_y[0] <= head_y_next;
            for (int i = 1; i < MAX_LEN; i++) begin
                if (i < int'(body.length)) begin
                    body.seg_x[i] <= body.seg_x[i-1];
                    body.seg_y[i] <= body.seg_y[i-1];
                end else begin
                    body.seg_x[i] <= tail_x;
                    body.seg_y[i] <= tail_y;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET)
            body.length <= LEN_INIT;
        else if (eaten && int'(body.length) < MAX_LEN)
            body.length <= body.length + 1'b1;
    end

endmodule

`default_nettype wire

//--- hw/food_gen.sv
`timescale 1ns/100ps
`default_nettype none

module food_gen
    import geom_pkg::*, game_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  game_state_t state,
    snake_if.view       body,
    output coord_t      food_x,
    output coord_t      food_y,
    output logic        eaten
);

    localparam int RND_W = $clog2(RND_TOP + 1);

    logic [RND_W-1:0] rnd;
    coord_t           new_x;
    coord_t           new_y;
    logic             hit;
    logic             outside;

    always_ff @(posedge CLK) begin
        if (RESET)
            rnd <= '0;
        else if (int'(rnd) == RND_TOP)
            rnd <= '0;
        else
            rnd <= rnd + 1'b1;
    end

    // offset grid, always lands inside the arena
    assign new_x = coord_t'((int'(rnd) % FOOD_COLS) * FOOD_GRID - FOOD_X0);
    assign new_y = coord_t'((int'(rnd) % FOOD_ROWS) * FOOD_GRID - FOOD_Y0);

    assign hit = dist2(body.seg_x[0], body.seg_y[0], food_x, food_y) < EAT_AREA;

    assign outside = (food_x >= WALL_X) || (food_x <= -WALL_X) ||
                     (food_y >= WALL_Y_TOP) || (food_y <= WALL_Y_BOT);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            food_x <= coord_t'(FOOD_PARK);
            food_y <= coord_t'(FOOD_PARK);
            eaten  <= 1'b0;
        end else begin
            eaten <= 1'b0;
            if (state == PLAY) begin
                if (hit) begin
                    food_x <= new_x;
                    food_y <= new_y;
                    eaten  <= 1'b1;
                end else if (outside) begin  // first placement comes from the park spot
                    food_x <= new_x;
                    food_y <= new_y;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pixel_render.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_render
    import geom_pkg::*, game_pkg::*;
#(
    parameter int MAX_LEN = 10
) (
    input  logic        CLK,
    input  logic        RESET,
    input  pix_t        pixel_x,
    input  pix_t        pixel_y,
    input  game_state_t state,
    snake_if.view       body,
    input  coord_t      food_x,
    input  coord_t      food_y,
    output rgb_t        pixel_rgb
);

    coord_t ax;
    coord_t ay;
    logic   on_snake;
    logic   on_food;
    logic   on_floor;
    rgb_t   rgb_next;

    // screen to arena
    assign ax = coord_t'(int'(pixel_x) - SCREEN_W / 2);
    assign ay = coord_t'(SCREEN_H / 2 - int'(pixel_y));

    always_comb begin
        on_snake = 1'b0;
        for (int i = 0; i < MAX_LEN; i++) begin
            if (i < int'(body.length) &&
                dist2(ax, ay, body.seg_x[i], body.seg_y[i]) < SEG_AREA)
                on_snake = 1'b1;
        end
    end

    // food is parked off screen in idle anyway
    assign on_food = (state != IDLE) && (dist2(ax, ay, food_x, food_y) < FOOD_AREA);

    assign on_floor = (ax > -WALL_X) && (ax < WALL_X) &&
                      (ay > WALL_Y_BOT) && (ay < FLOOR_Y_TOP);

    always_comb begin
        if (on_snake)
            rgb_next = COL_SNAKE;
        else if (on_food)
            rgb_next = COL_FOOD;
        else if (on_floor)
            rgb_next = COL_FLOOR;
        else
            rgb_next = COL_WALL;
    end

    always_ff @(posedge CLK) begin
        if (RESET)
            pixel_rgb <= COL_WALL;
        else
            pixel_rgb <= rgb_next;
    end

endmodule

`default_nettype wire

//--- hw/snake_game.sv
`timescale 1ns/100ps
`default_nettype none

module snake_game
    import geom_pkg::*, game_pkg::*;
#(
    parameter int STEP_CYCLES = 25000000,
    parameter int MAX_LEN     = 10
) (
    input  logic   CLK,
    input  logic   RESET,
    input  logic   btn_left,
    input  logic   btn_right,
    input  logic   btn_up,
    input  logic   btn_down,
    input  pix_t   pixel_x,
    input  pix_t   pixel_y,
    output rgb_t   pixel_rgb,
    output coord_t head_x,        // status for the score display
    output coord_t head_y,
    output coord_t food_x,
    output coord_t food_y,
    output len_t   snake_length,
    output logic   game_over,
    output logic   playing
);

    game_state_t state;
    dir_t        dir;
    logic        step;
    logic        eaten;

    snake_if #(.MAX_LEN(MAX_LEN)) snake ();

    game_ctrl #(.STEP_CYCLES(STEP_CYCLES)) u_ctrl (
        .CLK(CLK), .RESET(RESET),
        .btn_left(btn_left), .btn_right(btn_right),
        .btn_up(btn_up), .btn_down(btn_down),
        .body(snake), .state(state), .dir(dir), .step(step)
    );

    snake_body #(.MAX_LEN(MAX_LEN)) u_body (
        .CLK(CLK), .RESET(RESET),
        .step(step), .dir(dir), .eaten(eaten), .body(snake)
    );

    food_gen u_food (
        .CLK(CLK), .RESET(RESET), .state(state), .body(snake),
        .food_x(food_x), .food_y(food_y), .eaten(eaten)
    );

    pixel_render #(.MAX_LEN(MAX_LEN)) u_render (
        .CLK(CLK), .RESET(RESET),
        .pixel_x(pixel_x), .pixel_y(pixel_y), .state(state), .body(snake),
        .food_x(food_x), .food_y(food_y), .pixel_rgb(pixel_rgb)
    );

    assign head_x       = snake.seg_x[0];
    assign head_y       = snake.seg_y[0];
    assign snake_length = snake.length;
    assign game_over    = (state == OVER);
    assign playing      = (state == PLAY);

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic CLK,
    output logic RESET
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        RESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;   // released between edges
    end

endmodule

`default_nettype wire

//--- sim/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

function automatic longint sq_dist(input int ax, input int ay, input int bx, input int by);
    return longint'(ax - bx) * (ax - bx) + longint'(ay - by) * (ay - by);
endfunction

// expected colour from the model's pre-edge state
function automatic rgb_t ref_colour(input pix_t px, input pix_t py, input game_state_t st);
    int ax;
    int ay;
    ax = int'(coord_t'(int'(px) - 400));
    ay = int'(coord_t'(300 - int'(py)));
    for (int i = 0; i < int'(m_len); i++) begin
        if (sq_dist(ax, ay, m_seg_x[i], m_seg_y[i]) < 400)
            return COL_SNAKE;
    end
    if (st != IDLE && sq_dist(ax, ay, m_food_x, m_food_y) < 225)
        return COL_FOOD;
    if (ax > -375 && ax < 375 && ay > -275 && ay < 220)
        return COL_FLOOR;
    return COL_WALL;
endfunction

task automatic check_coord(input string name, input coord_t got, input coord_t exp);
    if (got !== exp)
        abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
endtask

task automatic check_length(input string name, input len_t got, input len_t exp);
    if (got !== exp)
        abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
        abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
endtask

task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    if (got !== exp)
        abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
endtask

`endif

//--- sim/tb_snake_game.sv
`timescale 1ns/100ps
`default_nettype none

module tb_snake_game
    import geom_pkg::*, game_pkg::*;
;

    localparam int STEP  = 8;
    localparam int LEN_MAX = 10;
    localparam int WATCHDOG_CYCLES = 40 * STEP + 2000;
    localparam int RANDOM_STEPS = 160;

    logic CLK, RESET;
    logic btn_left, btn_right, btn_up, btn_down;
    pix_t pixel_x, pixel_y;
    rgb_t pixel_rgb;
    coord_t head_x, head_y, food_x, food_y;
    len_t snake_length;
    logic game_over, playing;
    integer seed = 32'h6fc1;

    // reference model state
    game_state_t m_state;
    dir_t m_dir;
    int m_cnt, m_rnd;
    int m_eats;   // food eaten since reset
    logic m_step, m_eaten;
    coord_t m_seg_x [LEN_MAX];
    coord_t m_seg_y [LEN_MAX];
    len_t m_len;
    coord_t m_food_x, m_food_y;
    rgb_t m_rgb;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    `include "tb_checks.svh"

    tb_clock #(.PERIOD(20), .RESET_CYCLES(3)) u_clock (.CLK(CLK), .RESET(RESET));

    snake_game #(.STEP_CYCLES(STEP), .MAX_LEN(LEN_MAX)) DUT (
        .CLK(CLK), .RESET(RESET),
        .btn_left(btn_left), .btn_right(btn_right), .btn_up(btn_up), .btn_down(btn_down),
        .pixel_x(pixel_x), .pixel_y(pixel_y), .pixel_rgb(pixel_rgb),
        .head_x(head_x), .head_y(head_y), .food_x(food_x), .food_y(food_y),
        .snake_length(snake_length), .game_over(game_over), .playing(playing)
    );

    task automatic model_edge();
        coord_t nx [LEN_MAX];
        coord_t ny [LEN_MAX];
        int hx, hy;
        logic wall;
        if (RESET) begin
            m_state = IDLE;
            m_dir = RIGHT;
            m_cnt = 0;
            m_rnd = 0;
            m_eats = 0;
            m_step = 0;
            m_eaten = 0;
            m_len = 5;
            m_rgb = COL_WALL;
            m_food_x = 1000;
            m_food_y = 1000;
            for (int i = 0; i < LEN_MAX; i++) begin
                m_seg_x[i] = (i < 5) ? coord_t'((4 - i) * 20) : '0;
                m_seg_y[i] = '0;
            end
            return;
        end
        m_rgb = ref_colour(pixel_x, pixel_y, m_state);
        hx = m_seg_x[0];
        hy = m_seg_y[0];
        nx = m_seg_x;
        ny = m_seg_y;
        if (m_step) begin
            case (m_dir)
                RIGHT: nx[0] = coord_t'(hx + 30);
                LEFT:  nx[0] = coord_t'(hx - 30);
                UP:    ny[0] = coord_t'(hy + 30);
                default: ny[0] = coord_t'(hy - 30);
            endcase
            for (int i = 1; i < LEN_MAX; i++) begin
                nx[i] = (i < int'(m_len)) ? m_seg_x[i-1] : m_seg_x[m_len-1];
                ny[i] = (i < int'(m_len)) ? m_seg_y[i-1] : m_seg_y[m_len-1];
            end
        end
        if (m_eaten && m_len < LEN_MAX)
            m_len = m_len + 1;
        m_eaten = 0;
        if (m_state == PLAY) begin
            wall = m_food_x >= 375 || m_food_x <= -375 || m_food_y >= 225 || m_food_y <= -275;
            m_eaten = sq_dist(hx, hy, m_food_x, m_food_y) < 1225;
            if (m_eaten)
                m_eats++;
            if (m_eaten || wall) begin
                m_food_x = coord_t'((m_rnd % 16) * 20 - 160);
                m_food_y = coord_t'((m_rnd % 11) * 20 - 100);
            end
        end
        m_rnd = (m_rnd == 1000) ? 0 : m_rnd + 1;
        m_step = 0;
        wall = hx >= 375 || hx <= -375 || hy >= 225 || hy <= -275;
        if (m_state == PLAY) begin
            if (m_dir == RIGHT || m_dir == LEFT)
                m_dir = btn_up ? UP : (btn_down ? DOWN : m_dir);
            else
                m_dir = btn_left ? LEFT : (btn_right ? RIGHT : m_dir);
            if (wall) begin
                m_state = OVER;
            end else if (m_cnt == STEP - 1) begin
                m_cnt = 0;
                m_step = 1;
            end else begin
                m_cnt++;
            end
        end else if (m_state == IDLE) begin
            m_cnt = 0;
            if (btn_left | btn_right | btn_up | btn_down)
                m_state = PLAY;
        end
        m_seg_x = nx;
        m_seg_y = ny;
    endtask

    // model update and comparison
    always @(posedge CLK) begin
        model_edge();
        #1;
        check_coord("head_x", head_x, m_seg_x[0]);
        check_coord("head_y", head_y, m_seg_y[0]);
        check_coord("food_x", food_x, m_food_x);
        check_coord("food_y", food_y, m_food_y);
        check_length("snake_length", snake_length, m_len);
        check_flag("game_over", game_over, m_state == OVER);
        check_flag("playing", playing, m_state == PLAY);
        check_rgb("pixel_rgb", pixel_rgb, m_rgb);
    end

    // pixel queries, half aimed near a segment or the food
    always @(negedge CLK) begin
        logic [31:0] r;
        int k;
        r = $random(seed);
        k = int'(r[7:4]) % int'(m_len);
        if (r[0]) begin
            pixel_x = pix_t'(r[30:12] % 800);
            pixel_y = pix_t'($unsigned($random(seed)) % 600);
        end else if (r[1]) begin
            pixel_x = pix_t'(m_food_x + 400 + int'(r[13:8] % 41) - 20);
            pixel_y = pix_t'(300 - m_food_y + int'(r[21:16] % 41) - 20);
        end else begin
            pixel_x = pix_t'(m_seg_x[k] + 400 + int'(r[13:8] % 41) - 20);
            pixel_y = pix_t'(300 - m_seg_y[k] + int'(r[21:16] % 41) - 20);
        end
    end

    task automatic press(input logic [3:0] lrud);
        {btn_left, btn_right, btn_up, btn_down} = lrud;
        @(negedge CLK);
        {btn_left, btn_right, btn_up, btn_down} = 4'b0000;
    endtask

    task automatic wait_steps(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge CLK);
            if (m_step)
                seen++;
        end
    endtask

    // chase the food, turning away from the walls
    function automatic logic [3:0] choose_turn(input logic [31:0] r);
        int x, y, dx, dy;
        x = m_seg_x[0];
        y = m_seg_y[0];
        dx = m_food_x - x;
        dy = m_food_y - y;
        if (m_dir == RIGHT || m_dir == LEFT) begin
            if (x > 200 || x < -200 || (dx <= 15 && dx >= -15) ||
                (m_dir == RIGHT ? dx < 0 : dx > 0) || r[3:0] == 0)
                return (dy > 0 || (dy == 0 && y < 0)) ? 4'b0010 : 4'b0001;
        end else begin
            if (y > 150 || y < -200 || (dy <= 15 && dy >= -15) ||
                (m_dir == UP ? dy < 0 : dy > 0) || r[3:0] == 0)
                return (dx > 0 || (dx == 0 && x < 0)) ? 4'b0100 : 4'b1000;
        end
        return 4'b0000;
    endfunction

    initial begin
        coord_t hx, hy;
        {btn_left, btn_right, btn_up, btn_down} = 4'b0000;
        pixel_x = '0;
        pixel_y = '0;
        wait (RESET == 1'b0);
        repeat (12) @(negedge CLK);
        check_coord("head_x", head_x, 80);
        check_coord("head_y", head_y, 0);
        check_length("snake_length", snake_length, 5);
        check_coord("food_x", food_x, 1000);
        check_coord("food_y", food_y, 1000);
        check_flag("playing", playing, 1'b0);
        check_flag("game_over", game_over, 1'b0);

        press(4'b0100);      // start
        wait_steps(2);
        press(4'b0010);      // up
        wait_steps(2);
        press(4'b0001);      // reversal, ignored
        wait_steps(1);
        press(4'b1000);      // left
        wait_steps(1);
        press(4'b0100);      // reversal again
        wait_steps(1);
        @(negedge CLK);
        check_coord("head_x", head_x, 80);
        check_coord("head_y", head_y, 90);

        for (int s = 0; s < RANDOM_STEPS; s++) begin
            wait_steps(1);
            @(negedge CLK);
            press(choose_turn($random(seed)));
        end
        if (m_len != LEN_MAX)
            abort_run("snake did not grow to full length during random play");
        if (m_eats <= LEN_MAX - 5)
            abort_run("snake never ate at full length during random play");

        while (m_state != OVER) begin
            @(negedge CLK);
            btn_up = (m_dir == RIGHT || m_dir == LEFT);
            btn_left = (m_dir == DOWN);
        end
        {btn_left, btn_right, btn_up, btn_down} = 4'b0000;
        @(negedge CLK);
        check_flag("game_over", game_over, 1'b1);
        hx = m_seg_x[0];
        hy = m_seg_y[0];
        repeat (40) @(negedge CLK);
        check_coord("head_x", head_x, hx);
        check_coord("head_y", head_y, hy);
        check_length("snake_length", snake_length, LEN_MAX);
        $display("Everything OK");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge CLK);
        abort_run("timeout: the run took longer than all tests should need");
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+sim
hw/geom_pkg.sv
hw/game_pkg.sv
hw/snake_if.sv
hw/game_ctrl.sv
hw/snake_body.sv
hw/food_gen.sv
hw/pixel_render.sv
hw/snake_game.sv
sim/tb_clock.sv
sim/tb_snake_game.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the snake game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_snake_game \
    -f sim.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb 2>&1)"
status=$?
echo "$output"

if echo "$output" | grep -q "^Everything OK$"; then
    exit 0
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi
exit 1
